//--- src/stream_buf_pkg.sv
package stream_buf_pkg;

	// ##################################################
	// Memory geometry
	// ##################################################
	localparam int FEAT_W        = 16;
	localparam int ADDR_W        = 15;
	localparam int FEATURE_DEPTH = 24200;

	// ##################################################
	// Window scan
	// ##################################################
	localparam int WIN_TAPS     = 3;
	localparam int TAP_STRIDE   = 2;          // Words between taps
	localparam int WIN_CHANNELS = 2;
	localparam int POS_STRIDE   = WIN_TAPS * WIN_CHANNELS;
	localparam int POS_COUNT    = 1444;
	localparam int POS_W        = 11;

	// Addr to data through feature_ram
	localparam int READ_LATENCY = 4;

	// Consumer flow control
	localparam int CREDIT_MAX = 4;
	localparam int CREDIT_W   = 3;

	typedef logic [FEAT_W-1:0] feature_t;

	typedef struct packed {
		logic              en;
		logic [ADDR_W-1:0] addr;
		feature_t          data;
	} ram_wr_t;

	typedef struct packed {
		feature_t f0;                          // From buffer 0
		feature_t f1;                          // From buffer 1
	} feature_pair_t;

	typedef struct packed {
		logic [1:0]       tap;
		logic             channel;
		logic [POS_W-1:0] position;
	} win_pos_t;

endpackage

//--- src/feature_ram.sv
`timescale 1ns/1ps

module feature_ram import stream_buf_pkg::*; (
	input  logic              clk,
	input  ram_wr_t           i_wr,
	input  logic [ADDR_W-1:0] i_raddr,
	output feature_t          o_rdata
);

	// Address reg and array reg, the rest are output stages
	localparam int OUT_STAGES = READ_LATENCY - 2;

	feature_t mem [FEATURE_DEPTH];

	logic [ADDR_W-1:0] raddr_q;
	feature_t          rdata_q;
	feature_t          pipe_q [OUT_STAGES];

	// ##################################################
	// Write port
	// ##################################################
	always_ff @(posedge clk) begin
		if (i_wr.en) begin
			mem[i_wr.addr] <= i_wr.data;
		end
	end

	// ##################################################
	// Read port
	// ##################################################
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		rdata_q <= mem[raddr_q];
		pipe_q[0] <= rdata_q;
		for (int i = 1; i < OUT_STAGES; i++) begin
			pipe_q[i] <= pipe_q[i-1];
		end
	end

	assign o_rdata = pipe_q[OUT_STAGES-1];

endmodule

//--- src/window_addr_gen.sv
`timescale 1ns/1ps

module window_addr_gen import stream_buf_pkg::*; (
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_step,
	input  logic              i_clear,
	output logic [ADDR_W-1:0] o_raddr,
	output win_pos_t          o_pos
);

	logic [ADDR_W-1:0] base;
	logic [ADDR_W-1:0] offset;
	win_pos_t          pos;

	logic tap_wrap;
	logic chan_wrap;
	logic last_pos;

	assign tap_wrap  = (pos.tap == 2'(WIN_TAPS - 1));
	assign chan_wrap = (pos.channel == 1'(WIN_CHANNELS - 1));
	assign last_pos  = (pos.position == POS_W'(POS_COUNT - 1));

	always_ff @(posedge clk) begin
		if (i_reset || i_clear) begin
			base   <= '0;
			offset <= '0;
			pos    <= '0;
		end else if (i_step) begin
			if (tap_wrap && chan_wrap && last_pos) begin
				base   <= '0;                        // End of pass
				offset <= '0;
				pos    <= '0;
			end else if (tap_wrap && chan_wrap) begin
				base         <= base + ADDR_W'(POS_STRIDE - 1);
				offset       <= '0;
				pos.tap      <= '0;
				pos.channel  <= 1'b0;
				pos.position <= pos.position + 1'b1;
			end else if (tap_wrap) begin
				base        <= base + 1'b1;          // Next interleaved channel
				offset      <= '0;
				pos.tap     <= '0;
				pos.channel <= pos.channel + 1'b1;
			end else begin
				offset  <= offset + ADDR_W'(TAP_STRIDE);
				pos.tap <= pos.tap + 1'b1;
			end
		end
	end

	assign o_raddr = base + offset;
	assign o_pos   = pos;

endmodule

//--- src/result_ingest.sv
`timescale 1ns/1ps

module result_ingest import stream_buf_pkg::*; (
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_wen,
	input  logic [ADDR_W-1:0] i_waddr,
	input  feature_t          i_pool,
	input  feature_t          i_eltwise,
	input  logic              i_eltwise_sel,
	output ram_wr_t           o_wr
);

	feature_t wdata;

	assign wdata = i_eltwise_sel ? i_eltwise : i_pool;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_wr.en <= 1'b0;
		end else begin
			o_wr.en <= i_wen;
		end
	end

	// Payload follows the enable by the same edge
	always_ff @(posedge clk) begin
		o_wr.addr <= i_waddr;
		o_wr.data <= wdata;
	end

endmodule

//--- src/stream_ctrl.sv
`timescale 1ns/1ps

module stream_ctrl import stream_buf_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_start,
	input  logic     i_credit_return,
	input  win_pos_t i_pos,
	output logic     o_step,
	output logic     o_clear,
	output logic     o_feat_valid,
	output logic     o_done
);

	logic                busy;
	logic [CREDIT_W-1:0] credit_cnt;
	logic                issue;
	logic                last_read;

	logic [READ_LATENCY-1:0] valid_sr;   // Issue flags in flight
	logic [READ_LATENCY-1:0] last_sr;    // Marks the final read of a pass

	// ##################################################
	// Issue decision
	// ##################################################
	assign issue = busy && (credit_cnt != '0);

	assign last_read = (i_pos.position == POS_W'(POS_COUNT - 1))
		&& (i_pos.channel == 1'(WIN_CHANNELS - 1))
		&& (i_pos.tap == 2'(WIN_TAPS - 1));

	assign o_step  = issue;
	assign o_clear = i_start && !busy;     // Restart scan at address 0

	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy <= 1'b0;
		end else if (o_clear) begin
			busy <= 1'b1;
		end else if (issue && last_read) begin
			busy <= 1'b0;
		end
	end

	// ##################################################
	// Credits
	// ##################################################
	always_ff @(posedge clk) begin
		if (i_reset) begin
			credit_cnt <= CREDIT_W'(CREDIT_MAX);
		end else begin
			credit_cnt <= credit_cnt - CREDIT_W'(issue) + CREDIT_W'(i_credit_return);
		end
	end

	// ##################################################
	// Read pipeline tracking
	// ##################################################
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_sr <= '0;
			last_sr  <= '0;
		end else begin
			valid_sr <= {valid_sr[READ_LATENCY-2:0], issue};
			last_sr  <= {last_sr[READ_LATENCY-2:0], issue && last_read};
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_done <= 1'b0;
		end else begin
			o_done <= last_sr[READ_LATENCY-1];   // Cycle after last beat
		end
	end

	assign o_feat_valid = valid_sr[READ_LATENCY-1];

endmodule

//--- src/stream_buffer_top.sv
`timescale 1ns/1ps

module stream_buffer_top import stream_buf_pkg::*; (
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_start,
	input  ram_wr_t           i_ddr_wr,
	input  logic              i_res_wen,
	input  logic [ADDR_W-1:0] i_res_waddr,
	input  feature_t          i_pool,
	input  feature_t          i_eltwise,
	input  logic              i_eltwise_sel,
	input  logic              i_credit_return,
	output feature_pair_t     o_feat,
	output logic              o_feat_valid,
	output logic              o_done
);

	logic              step;
	logic              clear;
	logic [ADDR_W-1:0] raddr;
	win_pos_t          win_pos;
	ram_wr_t           res_wr;
	feature_t          rdata0;
	feature_t          rdata1;

	stream_ctrl ctrl_i (
		.clk             (clk),
		.i_reset         (i_reset),
		.i_start         (i_start),
		.i_credit_return (i_credit_return),
		.i_pos           (win_pos),
		.o_step          (step),
		.o_clear         (clear),
		.o_feat_valid    (o_feat_valid),
		.o_done          (o_done)
	);

	window_addr_gen addr_gen_i (
		.clk     (clk),
		.i_reset (i_reset),
		.i_step  (step),
		.i_clear (clear),
		.o_raddr (raddr),
		.o_pos   (win_pos)
	);

	result_ingest ingest_i (
		.clk           (clk),
		.i_reset       (i_reset),
		.i_wen         (i_res_wen),
		.i_waddr       (i_res_waddr),
		.i_pool        (i_pool),
		.i_eltwise     (i_eltwise),
		.i_eltwise_sel (i_eltwise_sel),
		.o_wr          (res_wr)
	);

	// ##################################################
	// Feature memories, both read at the same address
	// ##################################################
	feature_ram buf0_i (
		.clk     (clk),
		.i_wr    (i_ddr_wr),                     // DDR fill
		.i_raddr (raddr),
		.o_rdata (rdata0)
	);

	feature_ram buf1_i (
		.clk     (clk),
		.i_wr    (res_wr),                       // Layer results
		.i_raddr (raddr),
		.o_rdata (rdata1)
	);

	assign o_feat = '{f0: rdata0, f1: rdata1};

endmodule

//--- tests/fill_patterns.svh
// Buffer 0 word as loaded from DDR
function automatic feature_t buf0_word(logic [ADDR_W-1:0] a);
	return {1'b0, a} ^ 16'hC35A;
endfunction

function automatic feature_t pool_word(logic [ADDR_W-1:0] a);
	return {a, 1'b0} ^ 16'h5500;
endfunction

function automatic feature_t eltwise_word(logic [ADDR_W-1:0] a);
	return {a, 1'b1} ^ 16'h00AA;
endfunction

// Odd addresses take the element-wise result
function automatic feature_t result_word(logic [ADDR_W-1:0] a);
	return a[0] ? eltwise_word(a) : pool_word(a);
endfunction

//--- tests/stream_buffer_checker.sv
`timescale 1ns/1ps

module stream_buffer_checker import stream_buf_pkg::*; (
	input logic          clk,
	input logic          i_reset,
	input logic          i_start,
	input logic          i_credit_return,
	input feature_pair_t o_feat,
	input logic          o_feat_valid,
	input logic          o_done
);

	localparam int PASS_BEATS = POS_COUNT * POS_STRIDE;

	`include "fill_patterns.svh"

	int                error_count = 0;
	int unsigned       beat_cnt;       // Beat index within the pass
	int                outstanding;    // Beats not yet matched by a credit
	logic              started;
	logic              last_beat_q;
	logic [ADDR_W-1:0] exp_addr;

	// Tap fastest, then channel, then position
	function automatic logic [ADDR_W-1:0] window_addr(int unsigned k);
		int unsigned tap;
		int unsigned chan;
		int unsigned pos;
		tap  = k % WIN_TAPS;
		chan = (k / WIN_TAPS) % WIN_CHANNELS;
		pos  = k / POS_STRIDE;
		return ADDR_W'(POS_STRIDE * pos + chan + TAP_STRIDE * tap);
	endfunction

	assign exp_addr = window_addr(beat_cnt);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			beat_cnt    <= 0;
			outstanding <= 0;
			started     <= 1'b0;
			last_beat_q <= 1'b0;
		end else begin
			if (i_start) begin
				started <= 1'b1;
			end
			if (o_feat_valid) begin
				beat_cnt <= (beat_cnt == PASS_BEATS - 1) ? 0 : beat_cnt + 1;
			end
			last_beat_q <= o_feat_valid && (beat_cnt == PASS_BEATS - 1);
			outstanding <= outstanding + int'(o_feat_valid) - int'(i_credit_return);
		end
	end

	// ##################################################
	// Properties
	// ##################################################
	a_idle_before_start: assert property (@(posedge clk) disable iff (i_reset)
		!started |-> !o_feat_valid && !o_done)
		else begin
			error_count++;
			$error("Output became active before the first start");
		end

	a_buf0_data: assert property (@(posedge clk) disable iff (i_reset)
		o_feat_valid |-> o_feat.f0 == buf0_word(exp_addr))
		else begin
			error_count++;
			$error("FAILED at %0t: f0 is %h at address %0d", $time,
				$sampled(o_feat.f0), $sampled(exp_addr));
		end

	a_buf1_data: assert property (@(posedge clk) disable iff (i_reset)
		o_feat_valid |-> o_feat.f1 == result_word(exp_addr))
		else begin
			error_count++;
			$error("FAILED at %0t: f1 is %h at address %0d", $time,
				$sampled(o_feat.f1), $sampled(exp_addr));
		end

	a_credit_bound: assert property (@(posedge clk) disable iff (i_reset)
		outstanding <= CREDIT_MAX)
		else begin
			error_count++;
			$error("More beats in flight to the consumer than it has slots");
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (i_reset)
		o_done == last_beat_q)
		else begin
			error_count++;
			$error("Done pulse not aligned to the last beat of a pass");
		end

endmodule

bind stream_buffer_top stream_buffer_checker chk_i (.*);

//--- tests/tb_stream_buffer.sv
`timescale 1ns/1ps

module tb_stream_buffer import stream_buf_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int PASSES       = 2;
	localparam int MAX_DELAY    = 5;       // Consumer credit delay, cycles
	localparam int PASS_BEATS   = POS_COUNT * POS_STRIDE;
	localparam int WATCHDOG_CYCLES =
		FEATURE_DEPTH + PASSES * PASS_BEATS * (MAX_DELAY + 1) + 1000;

	`include "fill_patterns.svh"

	logic              clk = 1'b0;
	logic              i_reset;
	logic              i_start;
	ram_wr_t           i_ddr_wr;
	logic              i_res_wen;
	logic [ADDR_W-1:0] i_res_waddr;
	feature_t          i_pool;
	feature_t          i_eltwise;
	logic              i_eltwise_sel;
	logic              i_credit_return = 1'b0;
	feature_pair_t     o_feat;
	logic              o_feat_valid;
	logic              o_done;

	integer      seed = 65;
	int unsigned cycle_cnt = 0;
	int unsigned delay;
	int unsigned due_q [$];                // Cycle each credit goes back

	stream_buffer_top dut_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ##################################################
	// Consumer
	// ##################################################
	always @(negedge clk) begin
		if (o_feat_valid) begin
			delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
			due_q.push_back(cycle_cnt + delay);
		end
		if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
			void'(due_q.pop_front());
			i_credit_return = 1'b1;
		end else begin
			i_credit_return = 1'b0;
		end
		cycle_cnt++;
	end

	task automatic fill_buffers();
		logic [ADDR_W-1:0] addr;
		for (int a = 0; a < FEATURE_DEPTH; a++) begin
			addr          = ADDR_W'(a);
			i_ddr_wr      = '{en: 1'b1, addr: addr, data: buf0_word(addr)};
			i_res_wen     = 1'b1;
			i_res_waddr   = addr;
			i_pool        = pool_word(addr);
			i_eltwise     = eltwise_word(addr);
			i_eltwise_sel = addr[0];
			@(negedge clk);
		end
		i_ddr_wr  = '0;
		i_res_wen = 1'b0;
		repeat (2) @(negedge clk);         // Last result write lands
	endtask

	task automatic run_pass();
		i_start = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		do begin
			@(negedge clk);
		end while (!o_done);
	endtask

	initial begin
		i_reset       = 1'b1;
		i_start       = 1'b0;
		i_ddr_wr      = '0;
		i_res_wen     = 1'b0;
		i_res_waddr   = '0;
		i_pool        = '0;
		i_eltwise     = '0;
		i_eltwise_sel = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		i_reset = 1'b0;
		fill_buffers();
		for (int p = 0; p < PASSES; p++) begin
			run_pass();
		end
		if (dut_i.chk_i.error_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "Checker reported %0d errors", dut_i.chk_i.error_count);
		end
	end

	always @(negedge clk) begin
		if (dut_i.chk_i.error_count != 0) begin
			$display("TB FAILED");
			$fatal(1, "A checker assertion failed before %0t", $time);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("TB FAILED");
		$fatal(1, "Timeout, passes not done within %0d cycles", WATCHDOG_CYCLES);
	end

endmodule

//--- verilog.f
+incdir+tests
src/stream_buf_pkg.sv
src/feature_ram.sv
src/window_addr_gen.sv
src/result_ingest.sv
src/stream_ctrl.sv
src/stream_buffer_top.sv
tests/stream_buffer_checker.sv
tests/tb_stream_buffer.sv

//--- Makefile
TOP := tb_stream_buffer
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
